// ==== include/xv_macros.svh ====
/*
 * video timing for the small simulation frame
 * VRAM size and the host register numbers
 */
`ifndef XV_MACROS_SVH
`define XV_MACROS_SVH

// line segments in pixels adding up to 24
`define XV_H_VISIBLE 16
`define XV_H_FRONT 2
`define XV_H_SYNC 4
`define XV_H_BACK 2

// frame segments in lines adding up to 12
`define XV_V_VISIBLE 8
`define XV_V_FRONT 1
`define XV_V_SYNC 2
`define XV_V_BACK 1

`define XV_VRAM_ADDR_W 8            // 256 words

// host register numbers
`define XV_REG_INT_CTRL 4'd0
`define XV_REG_SYS_STATUS 4'd1
`define XV_REG_WR_ADDR 4'd2
`define XV_REG_DATA 4'd3
`define XV_REG_RD_ADDR 4'd4
`define XV_REG_RD_DATA 4'd5
`define XV_REG_BLIT_ADDR 4'd6
`define XV_REG_BLIT_COUNT 4'd7
`define XV_REG_BLIT_VALUE 4'd8

`endif

// ==== design/xv_bus_pkg.sv ====
/*
 * host bus types
 * data byte, register number, interrupt bits
 */
package xv_bus_pkg;

    // one byte on the 8-bit host bus
    typedef logic [7:0] byte_t;

    // selects one of the sixteen register ports
    typedef logic [3:0] reg_num_t;

    // interrupt bits
    // bit 0 frame start (vsync), bit 1 blit done
    typedef logic [1:0] intr_t;

endpackage

// ==== design/xv_video_pkg.sv ====
/*
 * VRAM and video types
 * words, addresses, scan counters, colour guns, blitter states
 */
package xv_video_pkg;

`include "xv_macros.svh"

    typedef logic [15:0] word_t;                    // one VRAM word
    typedef logic [`XV_VRAM_ADDR_W-1:0] addr_t;     // VRAM word address

    typedef logic [4:0] hcount_t;                   // pixel within line, 0..23
    typedef logic [3:0] vcount_t;                   // line within frame, 0..11

    typedef logic [3:0] color_t;                    // one gun of 12-bit RGB

    // fill engine
    typedef enum logic {
        IDLE,                                       // waiting for a start
        FILL                                        // writing one word per ack
    } blit_state_t;

endpackage

// ==== design/xv_reg_interface.sv ====
/*
 * host register interface
 * bus cycle decode, 16-bit write assembly, VRAM write/read pointers,
 * blitter register writes, status readback, interrupt mask and status
 */
`timescale 1ns/1ns

module xv_reg_interface (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  bus_cs_n_i,         // register strobe, active low
    input  logic                  bus_rd_nwr_i,       // 1 read, 0 write
    input  xv_bus_pkg::reg_num_t  bus_reg_num_i,
    input  logic                  bus_bytesel_i,      // 0 even (high) byte, 1 odd (low)
    input  xv_bus_pkg::byte_t     bus_data_i,
    output xv_bus_pkg::byte_t     bus_data_o,
    output logic                  bus_intr_o,
    output logic                  regs_vram_sel_o,
    output logic                  regs_wr_o,
    output xv_video_pkg::addr_t   regs_addr_o,
    output xv_video_pkg::word_t   regs_data_o,
    input  logic                  regs_ack_i,
    input  xv_video_pkg::word_t   vram_data_i,
    output logic                  blit_reg_wr_o,
    output logic [1:0]            blit_reg_sel_o,
    output xv_video_pkg::word_t   blit_reg_data_o,
    input  logic                  blit_busy_i,
    input  logic                  blit_done_i,
    input  logic                  frame_start_i,
    input  logic                  h_blank_i,
    input  logic                  v_blank_i
);

`include "xv_macros.svh"
    import xv_bus_pkg::*;
    import xv_video_pkg::*;

    logic   cs_n_q;                 // strobe last clock, for edge detect
    logic   cycle_start;            // first clock of a bus cycle
    logic   wr_odd;                 // odd byte write, the action point
    logic   rd_odd;
    byte_t  hold_hi;                // even byte waiting for its pair
    word_t  wr_word;
    addr_t  wr_addr;
    addr_t  rd_addr;
    addr_t  next_rd;                // address of the next prefetch
    word_t  rd_data;                // prefetched word
    logic   rd_pending;             // read acked, data due this clock
    logic   mem_busy;
    logic   start_wr;
    logic   start_rd;
    word_t  rd_word;                // readback mux
    intr_t  intr_mask;
    intr_t  intr_status;
    intr_t  intr_signal;
    intr_t  intr_clear;

    assign cycle_start = cs_n_q & ~bus_cs_n_i;
    assign wr_odd      = cycle_start & ~bus_rd_nwr_i & bus_bytesel_i;
    assign rd_odd      = cycle_start & bus_rd_nwr_i & bus_bytesel_i;
    assign wr_word     = {hold_hi, bus_data_i};
    assign mem_busy    = regs_vram_sel_o | rd_pending;

    // one VRAM request at a time, new ones dropped while busy
    assign start_wr = wr_odd && (bus_reg_num_i == `XV_REG_DATA) && !mem_busy;
    assign start_rd = !mem_busy && ((wr_odd && bus_reg_num_i == `XV_REG_RD_ADDR) ||
                                    (rd_odd && bus_reg_num_i == `XV_REG_RD_DATA));
    assign next_rd  = (bus_reg_num_i == `XV_REG_RD_ADDR) ? addr_t'(wr_word) : rd_addr + 1'b1;

    // blit regs 6..8 map to sel 0..2
    assign blit_reg_wr_o   = wr_odd && (bus_reg_num_i >= `XV_REG_BLIT_ADDR) &&
                             (bus_reg_num_i <= `XV_REG_BLIT_VALUE);
    assign blit_reg_sel_o  = 2'(bus_reg_num_i - `XV_REG_BLIT_ADDR);
    assign blit_reg_data_o = wr_word;

    assign intr_signal = {blit_done_i, frame_start_i};
    assign intr_clear  = (wr_odd && bus_reg_num_i == `XV_REG_INT_CTRL) ? bus_data_i[1:0] : '0;

    always_comb begin
        rd_word = '0;
        case (bus_reg_num_i)
            `XV_REG_INT_CTRL:   rd_word = {6'b0, intr_mask, 6'b0, intr_status};
            `XV_REG_SYS_STATUS: rd_word = {12'b0, v_blank_i, h_blank_i, blit_busy_i, mem_busy};
            `XV_REG_WR_ADDR:    rd_word = word_t'(wr_addr);
            `XV_REG_RD_ADDR:    rd_word = word_t'(rd_addr);
            `XV_REG_RD_DATA:    rd_word = rd_data;
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_q          <= 1'b1;
            regs_vram_sel_o <= 1'b0;
            rd_pending      <= 1'b0;
            wr_addr         <= '0;
            rd_addr         <= '0;
            intr_mask       <= '0;
            intr_status     <= '0;
            bus_intr_o      <= 1'b0;
        end else begin
            cs_n_q     <= bus_cs_n_i;
            rd_pending <= 1'b0;
            if (regs_ack_i) begin
                regs_vram_sel_o <= 1'b0;
                if (regs_wr_o) begin
                    wr_addr <= wr_addr + 1'b1;      // write done, step
                end else begin
                    rd_pending <= 1'b1;             // data lands next clock
                end
            end
            if (start_wr || start_rd) begin
                regs_vram_sel_o <= 1'b1;
            end
            if (start_rd) begin
                rd_addr <= next_rd;
            end
            if (wr_odd && bus_reg_num_i == `XV_REG_WR_ADDR) begin
                wr_addr <= addr_t'(wr_word);
            end
            if (wr_odd && bus_reg_num_i == `XV_REG_INT_CTRL) begin
                intr_mask <= hold_hi[1:0];          // mask in high byte
            end
            // pulse only for enabled bits not already pending
            bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
        end
    end

    always_ff @(posedge clk) begin
        if (cycle_start && !bus_rd_nwr_i && !bus_bytesel_i) begin
            hold_hi <= bus_data_i;
        end
        if (cycle_start) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (rd_pending) begin
            rd_data <= vram_data_i;
        end
        if (start_wr) begin
            regs_wr_o   <= 1'b1;
            regs_addr_o <= wr_addr;
            regs_data_o <= wr_word;
        end else if (start_rd) begin
            regs_wr_o   <= 1'b0;
            regs_addr_o <= next_rd;
        end
    end

endmodule

// ==== design/xv_blitter.sv ====
/*
 * blitter fill unit
 * ADDR, COUNT and VALUE registers, fill state machine, done pulse
 */
`timescale 1ns/1ns

module xv_blitter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 blit_reg_wr_i,
    input  logic [1:0]           blit_reg_sel_i,     // 0 addr, 1 count, 2 value
    input  xv_video_pkg::word_t  blit_reg_data_i,
    output logic                 blit_vram_sel_o,
    output logic                 blit_wr_o,
    output xv_video_pkg::addr_t  blit_addr_o,
    output xv_video_pkg::word_t  blit_data_o,
    input  logic                 blit_ack_i,
    output logic                 blit_busy_o,
    output logic                 blit_done_o
);

    import xv_video_pkg::*;

    localparam logic [1:0] SEL_ADDR  = 2'd0;
    localparam logic [1:0] SEL_COUNT = 2'd1;
    localparam logic [1:0] SEL_VALUE = 2'd2;

    blit_state_t state;
    addr_t       blit_remain;       // words left after the current one
    word_t       blit_value;

    assign blit_busy_o     = (state == FILL);
    assign blit_vram_sel_o = blit_busy_o;   // request held for the whole fill
    assign blit_wr_o       = blit_busy_o;   // fill only ever writes
    assign blit_data_o     = blit_value;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            blit_done_o <= 1'b0;
        end else begin
            blit_done_o <= 1'b0;
            case (state)
                IDLE: if (blit_reg_wr_i && blit_reg_sel_i == SEL_COUNT) state <= FILL;
                FILL: if (blit_ack_i && blit_remain == '0) begin
                    state       <= IDLE;
                    blit_done_o <= 1'b1;    // after the last ack
                end
                default: state <= IDLE;
            endcase
        end
    end

    // parameters only change while idle; addr wraps at 256
    always_ff @(posedge clk) begin
        if (state == IDLE && blit_reg_wr_i) begin
            case (blit_reg_sel_i)
                SEL_ADDR:  blit_addr_o <= addr_t'(blit_reg_data_i);
                SEL_COUNT: blit_remain <= addr_t'(blit_reg_data_i);
                SEL_VALUE: blit_value  <= blit_reg_data_i;
                default:   ;
            endcase
        end else if (blit_ack_i) begin
            blit_addr_o <= blit_addr_o + 1'b1;
            blit_remain <= blit_remain - 1'b1;
        end
    end

endmodule

// ==== design/xv_video_gen.sv ====
/*
 * video generator
 * scan counters, pixel fetch addresses, blank flags,
 * delayed syncs and display enable, 12-bit colour out
 */
`timescale 1ns/1ns

module xv_video_gen (
    input  logic                  clk,
    input  logic                  reset_i,
    output logic                  vgen_sel_o,
    output xv_video_pkg::addr_t   vgen_addr_o,
    input  xv_video_pkg::word_t   vram_data_i,
    output xv_video_pkg::color_t  red_o,
    output xv_video_pkg::color_t  green_o,
    output xv_video_pkg::color_t  blue_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_de_o,
    output logic                  h_blank_o,
    output logic                  v_blank_o,
    output logic                  frame_start_o
);

`include "xv_macros.svh"
    import xv_video_pkg::*;

    localparam hcount_t H_VIS  = hcount_t'(`XV_H_VISIBLE);
    localparam hcount_t H_SON  = hcount_t'(`XV_H_VISIBLE + `XV_H_FRONT);
    localparam hcount_t H_SOFF = hcount_t'(H_SON + `XV_H_SYNC);
    localparam hcount_t H_LAST = hcount_t'(H_SOFF + `XV_H_BACK - 1);
    localparam vcount_t V_VIS  = vcount_t'(`XV_V_VISIBLE);
    localparam vcount_t V_SON  = vcount_t'(`XV_V_VISIBLE + `XV_V_FRONT);
    localparam vcount_t V_SOFF = vcount_t'(V_SON + `XV_V_SYNC);
    localparam vcount_t V_LAST = vcount_t'(V_SOFF + `XV_V_BACK - 1);

    hcount_t h_count;
    vcount_t v_count;

    assign h_blank_o   = (h_count >= H_VIS);
    assign v_blank_o   = (v_count >= V_VIS);
    assign vgen_sel_o  = !h_blank_o && !v_blank_o;      // visible pixels only
    assign vgen_addr_o = addr_t'({v_count, h_count[3:0]});   // line*16 + column

    // word lands one clock after fetch, de already delayed to match
    assign {red_o, green_o, blue_o} = dv_de_o ? vram_data_i[11:0] : 12'h000;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count       <= '0;
            v_count       <= '0;
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            dv_de_o       <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            if (h_count == H_LAST) begin
                h_count <= '0;
                v_count <= (v_count == V_LAST) ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
            // one clock behind the counters, syncs active high
            hsync_o       <= (h_count >= H_SON) && (h_count < H_SOFF);
            vsync_o       <= (v_count >= V_SON) && (v_count < V_SOFF);
            dv_de_o       <= vgen_sel_o;
            frame_start_o <= (h_count == '0) && (v_count == V_SON);   // first vsync clock
        end
    end

endmodule

// ==== design/xv_vram_arb.sv ====
/*
 * VRAM and its arbiter
 * 256-word single-port memory, fixed priority video > regs > blit
 */
`timescale 1ns/1ns

module xv_vram_arb (
    input  logic                 clk,
    input  logic                 vgen_sel_i,
    input  xv_video_pkg::addr_t  vgen_addr_i,
    input  logic                 regs_vram_sel_i,
    input  logic                 regs_wr_i,
    input  xv_video_pkg::addr_t  regs_addr_i,
    input  xv_video_pkg::word_t  regs_data_i,
    output logic                 regs_ack_o,
    input  logic                 blit_vram_sel_i,
    input  logic                 blit_wr_i,
    input  xv_video_pkg::addr_t  blit_addr_i,
    input  xv_video_pkg::word_t  blit_data_i,
    output logic                 blit_ack_o,
    output xv_video_pkg::word_t  vram_data_o
);

    import xv_video_pkg::*;

    word_t vram_mem [2**$bits(addr_t)];
    logic  mem_wr;
    addr_t mem_addr;
    word_t mem_wdata;

    // video is never stalled
    assign regs_ack_o = regs_vram_sel_i & ~vgen_sel_i;
    assign blit_ack_o = blit_vram_sel_i & ~vgen_sel_i & ~regs_vram_sel_i;

    always_comb begin
        mem_addr  = vgen_addr_i;    // video or idle
        mem_wr    = 1'b0;
        mem_wdata = blit_data_i;
        if (regs_ack_o) begin
            mem_addr  = regs_addr_i;
            mem_wr    = regs_wr_i;
            mem_wdata = regs_data_i;
        end else if (blit_ack_o) begin
            mem_addr  = blit_addr_i;
            mem_wr    = blit_wr_i;
        end
    end

    // read data one clock after grant
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            vram_mem[mem_addr] <= mem_wdata;
        end
        vram_data_o <= vram_mem[mem_addr];
    end

endmodule

// ==== design/xv_top.sv ====
/*
 * xv_lite top level
 * register interface, blitter, video generator, VRAM arbiter
 */
`timescale 1ns/1ns

module xv_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  bus_cs_n_i,
    input  logic                  bus_rd_nwr_i,
    input  xv_bus_pkg::reg_num_t  bus_reg_num_i,
    input  logic                  bus_bytesel_i,
    input  xv_bus_pkg::byte_t     bus_data_i,
    output xv_bus_pkg::byte_t     bus_data_o,
    output logic                  bus_intr_o,
    output xv_video_pkg::color_t  red_o,
    output xv_video_pkg::color_t  green_o,
    output xv_video_pkg::color_t  blue_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_de_o
);

    import xv_video_pkg::*;

    word_t      vram_data;          // shared read data, all users
    logic       vgen_sel;
    addr_t      vgen_addr;
    logic       regs_vram_sel, regs_wr, regs_ack;
    addr_t      regs_addr;
    word_t      regs_data;
    logic       blit_vram_sel, blit_wr, blit_ack;
    addr_t      blit_addr;
    word_t      blit_data;
    logic       blit_reg_wr;
    logic [1:0] blit_reg_sel;
    word_t      blit_reg_data;
    logic       blit_busy, blit_done;
    logic       h_blank, v_blank, frame_start;

    xv_reg_interface u_regs (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o, .bus_intr_o,
        .regs_vram_sel_o(regs_vram_sel), .regs_wr_o(regs_wr), .regs_addr_o(regs_addr),
        .regs_data_o(regs_data), .regs_ack_i(regs_ack), .vram_data_i(vram_data),
        .blit_reg_wr_o(blit_reg_wr), .blit_reg_sel_o(blit_reg_sel),
        .blit_reg_data_o(blit_reg_data), .blit_busy_i(blit_busy), .blit_done_i(blit_done),
        .frame_start_i(frame_start), .h_blank_i(h_blank), .v_blank_i(v_blank)
    );

    xv_blitter u_blit (
        .clk, .reset_i, .blit_reg_wr_i(blit_reg_wr), .blit_reg_sel_i(blit_reg_sel),
        .blit_reg_data_i(blit_reg_data), .blit_vram_sel_o(blit_vram_sel),
        .blit_wr_o(blit_wr), .blit_addr_o(blit_addr), .blit_data_o(blit_data),
        .blit_ack_i(blit_ack), .blit_busy_o(blit_busy), .blit_done_o(blit_done)
    );

    xv_video_gen u_vgen (
        .clk, .reset_i, .vgen_sel_o(vgen_sel), .vgen_addr_o(vgen_addr),
        .vram_data_i(vram_data), .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .dv_de_o,
        .h_blank_o(h_blank), .v_blank_o(v_blank), .frame_start_o(frame_start)
    );

    xv_vram_arb u_arb (
        .clk, .vgen_sel_i(vgen_sel), .vgen_addr_i(vgen_addr),
        .regs_vram_sel_i(regs_vram_sel), .regs_wr_i(regs_wr), .regs_addr_i(regs_addr),
        .regs_data_i(regs_data), .regs_ack_o(regs_ack),
        .blit_vram_sel_i(blit_vram_sel), .blit_wr_i(blit_wr), .blit_addr_i(blit_addr),
        .blit_data_i(blit_data), .blit_ack_o(blit_ack), .vram_data_o(vram_data)
    );

endmodule

// ==== verif/xv_clkgen.sv ====
/*
 * testbench clock and reset
 * 100 ns clock, reset high for the first two cycles
 */
`timescale 1ns/1ns

module xv_clkgen #(
    parameter int PERIOD       = 100,      // ns
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                     // release away from the sampling edge
        reset_o = 1'b0;
    end

endmodule

// ==== verif/xv_checker.sv ====
/*
 * testbench checker
 * frame timing, blank and pixel colour, interrupt pulse count,
 * value compares and error counts
 */
`timescale 1ns/1ns

module xv_checker (
    input logic                  clk,
    input logic                  reset_i,
    input xv_video_pkg::color_t  red_i,
    input xv_video_pkg::color_t  green_i,
    input xv_video_pkg::color_t  blue_i,
    input logic                  hsync_i,
    input logic                  vsync_i,
    input logic                  dv_de_i,
    input logic                  bus_intr_i
);

    int          error_count = 0;
    int          check_count = 0;
    int          frame_count = 0;           // vsync rising edges seen
    int          intr_clocks = 0;           // clocks with the interrupt high
    int          de_clocks   = 0;           // per frame
    int          hsync_rises = 0;           // per frame
    int          pix_count   = 0;
    logic        hsync_q     = 1'b0;
    logic        vsync_q     = 1'b0;
    logic        pix_armed   = 1'b0;        // start on the next vsync rise
    logic        pix_active  = 1'b0;        // inside the checked frame
    logic        pix_done    = 1'b0;
    logic [11:0] pix_expect  = '0;
    logic [11:0] rgb;

    assign rgb = {red_i, green_i, blue_i};

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    // colour for every visible pixel of the next whole frame
    task automatic arm_pixel_check(input logic [11:0] color);
        pix_expect = color;
        pix_done   = 1'b0;
        pix_armed  = 1'b1;
    endtask

    // hands over the count and starts a new one
    task automatic take_intr_clocks(output int count);
        count       = intr_clocks;
        intr_clocks = 0;
    endtask

    always @(negedge clk) begin
        if (reset_i) begin
            hsync_q     = 1'b0;
            vsync_q     = 1'b0;
            de_clocks   = 0;
            hsync_rises = 0;
        end else begin
            if (vsync_i && !vsync_q) begin
                if (frame_count > 0) begin      // first rise only opens a frame
                    check_value("frame de clocks", 16'd128, 16'(de_clocks));
                    check_value("frame hsync pulses", 16'd12, 16'(hsync_rises));
                end
                if (pix_active) begin
                    check_value("pixels in frame", 16'd128, 16'(pix_count));
                    pix_active = 1'b0;
                    pix_done   = 1'b1;
                end
                if (pix_armed) begin
                    pix_armed  = 1'b0;
                    pix_active = 1'b1;
                    pix_count  = 0;
                end
                frame_count++;
                de_clocks   = 0;
                hsync_rises = 0;
            end
            if (dv_de_i) de_clocks++;
            if (hsync_i && !hsync_q) hsync_rises++;
            if (bus_intr_i) intr_clocks++;
            if (!dv_de_i) begin
                check_value("blank colour", 16'h0000, {4'h0, rgb});   // black outside de
            end else if (pix_active) begin
                check_value("pixel colour", {4'h0, pix_expect}, {4'h0, rgb});
                pix_count++;
            end
            hsync_q = hsync_i;
            vsync_q = vsync_i;
        end
    end

endmodule

// ==== verif/xv_tb.sv ====
/*
 * testbench top
 * runs the patterns file as host bus cycles on falling edges,
 * polls with timeouts, prints the closing summary
 */
`timescale 1ns/1ns

module xv_tb;

    import xv_bus_pkg::*;
    import xv_video_pkg::*;

    localparam int          MAX_OPS     = 128;
    localparam int          POLL_LIMIT  = 1000;     // register reads per poll
    localparam int          FRAME_LIMIT = 400;      // clocks allowed per frame
    localparam logic [31:0] SEED        = 32'h8ddce58b;

    logic        clk, reset;
    logic        bus_cs_n, bus_rd_nwr, bus_bytesel, bus_intr;
    reg_num_t    bus_reg_num;
    byte_t       bus_wdata, bus_rdata;
    color_t      red, green, blue;
    logic        hsync, vsync, dv_de;
    logic [15:0] patterns [4*MAX_OPS];             // op reg data expected per step

    xv_clkgen u_clkgen (.clk(clk), .reset_o(reset));

    xv_top u_xv_top (
        .clk(clk), .reset_i(reset), .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr),
        .bus_reg_num_i(bus_reg_num), .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_wdata),
        .bus_data_o(bus_rdata), .bus_intr_o(bus_intr), .red_o(red), .green_o(green),
        .blue_o(blue), .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    xv_checker u_chk (
        .clk(clk), .reset_i(reset), .red_i(red), .green_i(green), .blue_i(blue),
        .hsync_i(hsync), .vsync_i(vsync), .dv_de_i(dv_de), .bus_intr_i(bus_intr)
    );

    // one byte cycle with the strobe low over three rising edges and a random idle after
    task automatic bus_cycle(input logic rd, input reg_num_t num, input logic odd,
                             input byte_t wdata, output byte_t rdata);
        int gap;
        @(negedge clk);
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = num;
        bus_bytesel = odd;
        bus_wdata   = wdata;
        repeat (3) @(negedge clk);
        rdata    = bus_rdata;                       // registered since the first edge
        bus_cs_n = 1'b1;
        gap      = int'($urandom % 4);
        repeat (gap) @(negedge clk);
    endtask

    task automatic write_word(input reg_num_t num, input word_t value);
        byte_t unused;
        bus_cycle(1'b0, num, 1'b0, value[15:8], unused);    // high byte held
        bus_cycle(1'b0, num, 1'b1, value[7:0], unused);     // action on low byte
    endtask

    task automatic read_word(input reg_num_t num, output word_t value);
        byte_t hi, lo;
        bus_cycle(1'b1, num, 1'b0, 8'h00, hi);
        bus_cycle(1'b1, num, 1'b1, 8'h00, lo);
        value = {hi, lo};
    endtask

    task automatic poll_clear(input int step, input reg_num_t num, input word_t mask);
        word_t value;
        int    tries;
        tries = 0;
        read_word(num, value);
        while ((value & mask) !== 16'h0000 && tries < POLL_LIMIT) begin
            tries++;
            read_word(num, value);
        end
        if ((value & mask) !== 16'h0000) begin
            u_chk.report_failure($sformatf(
                "step %0d timed out, bits %h of register %0d never cleared", step, mask, num));
        end
    endtask

    task automatic wait_frames(input int step, input int count);
        int target;
        int clocks;
        target = u_chk.frame_count + count;
        clocks = 0;
        while (u_chk.frame_count < target && clocks < FRAME_LIMIT * (count + 1)) begin
            @(posedge clk);
            clocks++;
        end
        if (u_chk.frame_count < target) begin
            u_chk.report_failure($sformatf("step %0d timed out waiting for %0d frames",
                                           step, count));
        end
    endtask

    task automatic check_intr_pulses(input int step, input word_t expected);
        int count;
        @(posedge clk);                             // away from the checker's edge
        u_chk.take_intr_clocks(count);
        u_chk.check_value($sformatf("step %0d interrupt pulses", step), expected, 16'(count));
    endtask

    task automatic check_pixel_frame(input int step, input logic [11:0] color);
        int clocks;
        @(posedge clk);
        u_chk.arm_pixel_check(color);
        clocks = 0;
        while (!u_chk.pix_done && clocks < FRAME_LIMIT * 3) begin
            @(posedge clk);
            clocks++;
        end
        if (!u_chk.pix_done) begin
            u_chk.report_failure($sformatf("step %0d timed out, no full frame of pixels checked",
                                           step));
        end
    endtask

    initial begin : main
        int          step;
        int          tries;
        logic [15:0] op, num, data, expected;
        word_t       value;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = '0;
        bus_bytesel = 1'b0;
        bus_wdata   = '0;
        void'($urandom(SEED));
        $readmemh("verif/xv_patterns.mem", patterns);
        tries = 0;
        while (reset !== 1'b0 && tries < 20) begin
            @(posedge clk);
            tries++;
        end
        if (reset !== 1'b0) u_chk.report_failure("reset was never released");
        step = 0;
        while (step < MAX_OPS && patterns[4*step] !== 16'h000f) begin
            op       = patterns[4*step];
            num      = patterns[4*step+1];
            data     = patterns[4*step+2];
            expected = patterns[4*step+3];
            case (op[3:0])
                4'h0: write_word(reg_num_t'(num[3:0]), data);
                4'h1: begin
                    read_word(reg_num_t'(num[3:0]), value);
                    u_chk.check_value($sformatf("step %0d read reg %0d", step, num),
                                      expected & data, value & data);   // data is the mask
                end
                4'h2: poll_clear(step, reg_num_t'(num[3:0]), data);
                4'h3: wait_frames(step, int'(data));
                4'h4: check_intr_pulses(step, expected);
                4'h5: check_pixel_frame(step, expected[11:0]);
                default: u_chk.report_failure($sformatf("step %0d has unknown operation %h",
                                                        step, op));
            endcase
            step++;
        end
        $display("summary: %0d steps, %0d checks, %0d errors",
                 step, u_chk.check_count, u_chk.error_count);
        if (u_chk.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verif/xv_patterns.mem ====
// op reg data expected, hex; op 0 write, 1 read with data as mask, 2 poll until data bits clear
// op 3 wait data frames, 4 interrupt clocks since last op 4, 5 pixel frame colour, f end
4 0 0000 0000
0 2 0010 0000
0 3 1234 0000
2 1 0001 0000
0 3 abcd 0000
2 1 0001 0000
0 3 5a5a 0000
2 1 0001 0000
1 2 ffff 0013
0 4 0010 0000
2 1 0001 0000
1 5 ffff 1234
2 1 0001 0000
1 5 ffff abcd
2 1 0001 0000
1 4 ffff 0012
0 0 0203 0000
0 6 0011 0000
0 8 0777 0000
0 7 0000 0000
2 1 0002 0000
4 0 0000 0001
1 0 ff02 0202
0 0 0202 0000
1 0 0002 0000
2 1 0001 0000
0 4 0010 0000
2 1 0001 0000
1 5 ffff 1234
2 1 0001 0000
1 5 ffff 0777
2 1 0001 0000
1 5 ffff 5a5a
0 0 0003 0000
0 7 0000 0000
2 1 0002 0000
4 0 0000 0000
1 0 ff02 0002
0 0 0002 0000
1 0 0002 0000
0 6 0000 0000
0 8 f5a3 0000
0 7 00ff 0000
2 1 0002 0000
5 0 0000 05a3
3 0 0002 0000
f 0 0000 0000

// ==== Makefile ====
# Verilator build and run of the xv_lite testbench

VERILATOR ?= verilator
TOP       ?= xv_tb
LINT_TOP  ?= xv_top
FILELIST  ?= xv_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timescale 1ns/1ns --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== xv_lite.f ====
+incdir+include
design/xv_bus_pkg.sv
design/xv_video_pkg.sv
design/xv_reg_interface.sv
design/xv_blitter.sv
design/xv_video_gen.sv
design/xv_vram_arb.sv
design/xv_top.sv
verif/xv_clkgen.sv
verif/xv_checker.sv
verif/xv_tb.sv
